// File: design/alu.sv
`timescale 1ns/10ps

module alu import mipsPkg::*; (
    input  aluOpE                aluOp_i,
    input  logic [dataWidth-1:0] opA_i,
    input  logic [dataWidth-1:0] opB_i,
    output logic [dataWidth-1:0] res_o,
    output logic [dataWidth-1:0] sum_o
);

    logic [dataWidth-1:0] diff;
    logic                 lessThan;

    // Adder result, also used for addresses and branch targets
    assign sum_o = opA_i + opB_i;
    assign diff  = opA_i - opB_i;

    // Signed compare for slt
    assign lessThan = $signed(opA_i) < $signed(opB_i);

    always_comb begin
        case (aluOp_i)
            aluAdd:  res_o = sum_o;
            aluSub:  res_o = diff;
            aluAnd:  res_o = opA_i & opB_i;
            aluOr:   res_o = opA_i | opB_i;
            aluSlt:  res_o = {{(dataWidth-1){1'b0}}, lessThan};
            // Second operand unchanged, jal return address
            aluPass: res_o = opB_i;
            default: res_o = sum_o;
        endcase
    end

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import mipsPkg::*; (
    input  logic [regAddrWidth-1:0] idRs_i,
    input  logic [regAddrWidth-1:0] idRt_i,
    input  idExT                    exCtl_i,
    input  exMemT                   memCtl_i,
    input  memWbT                   wbCtl_i,
    output fwdSelE                  fwdA_o,
    output fwdSelE                  fwdB_o,
    output logic                    loadUseStall_o
);

    // Youngest producer wins, memory stage before writeback
    function automatic fwdSelE pickSource(input logic [regAddrWidth-1:0] src);
        logic memHit;
        logic wbHit;
        memHit = memCtl_i.regWrite && (memCtl_i.dest != '0) && (memCtl_i.dest == src);
        wbHit  = wbCtl_i.regWrite && (wbCtl_i.dest != '0) && (wbCtl_i.dest == src);
        if (memHit) begin
            return fwdMem;
        end else if (wbHit) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    ////////////////////////////////////////
    // Execute operand forwarding
    ////////////////////////////////////////

    always_comb begin
        fwdA_o = pickSource(exCtl_i.rs);
        fwdB_o = pickSource(exCtl_i.rt);
    end

    ////////////////////////////////////////
    // Load-use interlock
    ////////////////////////////////////////

    // Load in execute feeding the decode instruction
    // rt may be a destination too, costs one spare bubble at most
    always_comb begin
        loadUseStall_o = 1'b0;
        if (exCtl_i.ctrl.memRead && (exCtl_i.dest != '0)) begin
            if ((exCtl_i.dest == idRs_i) || (exCtl_i.dest == idRt_i)) begin
                loadUseStall_o = 1'b1;
            end
        end
    end

endmodule

// File: design/mipsControl.sv
`timescale 1ns/10ps

module mipsControl import mipsPkg::*; (
    input  logic [31:0] inst_i,
    output ctrlT        ctrl_o
);

    opcodeE opcode;
    functE  funct;

    // Major opcode and R-type function fields
    assign opcode = opcodeE'(inst_i[31:26]);
    assign funct  = functE'(inst_i[5:0]);

    always_comb begin
        // Unknown encodings fall through as a bubble
        ctrl_o = '0;
        case (opcode)
            opRtype: begin
                case (funct)
                    fnAdd: begin
                        ctrl_o.regWrite = 1'b1;
                        ctrl_o.regDst   = 1'b1;
                        ctrl_o.aluOp    = aluAdd;
                    end
                    fnSub: begin
                        ctrl_o.regWrite = 1'b1;
                        ctrl_o.regDst   = 1'b1;
                        ctrl_o.aluOp    = aluSub;
                    end
                    fnAnd: begin
                        ctrl_o.regWrite = 1'b1;
                        ctrl_o.regDst   = 1'b1;
                        ctrl_o.aluOp    = aluAnd;
                    end
                    fnOr: begin
                        ctrl_o.regWrite = 1'b1;
                        ctrl_o.regDst   = 1'b1;
                        ctrl_o.aluOp    = aluOr;
                    end
                    fnSlt: begin
                        ctrl_o.regWrite = 1'b1;
                        ctrl_o.regDst   = 1'b1;
                        ctrl_o.aluOp    = aluSlt;
                    end
                    // Redirect from decode, nothing written
                    fnJr: ctrl_o.jumpReg = 1'b1;
                    default: ctrl_o = '0;
                endcase
            end
            opAddi: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluAdd;
            end
            opLw: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.memToReg  = 1'b1;
                ctrl_o.memRead   = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluAdd;
            end
            opSw: begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluAdd;
            end
            // Branches use the adder for the target
            opBeq: ctrl_o.beq = 1'b1;
            opBne: ctrl_o.bne = 1'b1;
            opJ:   ctrl_o.jumpImm = 1'b1;
            opJal: begin
                ctrl_o.jumpImm  = 1'b1;
                ctrl_o.link     = 1'b1;
                ctrl_o.regWrite = 1'b1;
                // Return address passes straight through the ALU
                ctrl_o.aluOp    = aluPass;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: design/mipsPipeline.sv
`timescale 1ns/10ps

module mipsPipeline import mipsPkg::*; (
    input  logic        clk,
    input  logic        reset_i,

    // Instruction cache port
    output logic        icacheRen_o,
    output logic [29:0] icacheAddr_o,
    input  logic [31:0] icacheRdata_i,
    input  logic        icacheStall_i,

    // Data cache port
    output logic        dcacheRen_o,
    output logic        dcacheWen_o,
    output logic [29:0] dcacheAddr_o,
    output logic [31:0] dcacheWdata_o,
    input  logic [31:0] dcacheRdata_i,
    input  logic        dcacheStall_i
);

    // Whole-pipeline hold while a cache is busy
    logic freeze;

    // Fetch
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] nextPc;

    // Pipeline registers
    ifIdT  ifId;
    idExT  idEx;
    exMemT exMem;
    memWbT memWb;

    // Decode
    ctrlT                    idCtrl;
    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [regAddrWidth-1:0] idRd;
    logic [regAddrWidth-1:0] idDest;
    logic [dataWidth-1:0]    idImm;
    logic [dataWidth-1:0]    rdataA;
    logic [dataWidth-1:0]    rdataB;
    logic [dataWidth-1:0]    jumpTarget;
    logic                    idJump;
    logic                    loadUseStall;

    // Execute
    fwdSelE               fwdA;
    fwdSelE               fwdB;
    logic [dataWidth-1:0] exRsFwd;
    logic [dataWidth-1:0] exRtFwd;
    logic [dataWidth-1:0] aluOpA;
    logic [dataWidth-1:0] aluOpB;
    logic [dataWidth-1:0] aluRes;
    logic [dataWidth-1:0] aluSum;
    logic                 exIsBranch;
    logic                 branchTaken;

    // Writeback
    logic [dataWidth-1:0] wbData;

    assign freeze = icacheStall_i || dcacheStall_i;

    // Operand select shared by both execute sources
    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSelE               sel,
        input logic [dataWidth-1:0] regVal
    );
        case (sel)
            fwdMem:  return exMem.aluRes;
            fwdWb:   return wbData;
            default: return regVal;
        endcase
    endfunction

    ////////////////////////////////////////
    // IF stage
    ////////////////////////////////////////

    assign pcPlus4 = pc + dataWidth'(4);

    // Older branch in EX beats any jump sitting in ID
    always_comb begin
        if (branchTaken) begin
            nextPc = aluSum;
        end else if (idCtrl.jumpImm) begin
            nextPc = jumpTarget;
        end else if (idCtrl.jumpReg) begin
            nextPc = rdataA;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc <= resetPc;
        end else if (!freeze && !loadUseStall) begin
            pc <= nextPc;
        end
    end

    // Word-addressed fetch
    assign icacheRen_o  = !reset_i;
    assign icacheAddr_o = pc[31:2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ifId <= '0;
        end else if (!freeze) begin
            if (branchTaken) begin
                // Wrong-path fetch squashed
                ifId.inst    <= nopInst;
                ifId.pcPlus4 <= '0;
            end else if (loadUseStall) begin
                // Hold, jump in ID redirects next cycle
                ifId <= ifId;
            end else if (idJump) begin
                ifId.inst    <= nopInst;
                ifId.pcPlus4 <= '0;
            end else begin
                ifId.inst    <= icacheRdata_i;
                ifId.pcPlus4 <= pcPlus4;
            end
        end
    end

    ////////////////////////////////////////
    // ID stage
    ////////////////////////////////////////

    mipsControl uControl (
        .inst_i (ifId.inst),
        .ctrl_o (idCtrl)
    );

    assign idRs   = ifId.inst[25:21];
    assign idRt   = ifId.inst[20:16];
    assign idRd   = ifId.inst[15:11];
    assign idJump = idCtrl.jumpImm || idCtrl.jumpReg;

    // jal targets r31, R-type rd, others rt
    assign idDest = idCtrl.link   ? regAddrWidth'(linkReg) :
                    idCtrl.regDst ? idRd                   :
                    idRt;

    // Sign extension
    assign idImm = {{(dataWidth-16){ifId.inst[15]}}, ifId.inst[15:0]};

    // Region of PC+4, word index shifted up
    assign jumpTarget = {ifId.pcPlus4[31:28], ifId.inst[25:0], 2'b00};

    regFile uRegFile (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (memWb.regWrite),
        .waddr_i  (memWb.dest),
        .wdata_i  (wbData),
        .raddrA_i (idRs),
        .raddrB_i (idRt),
        .rdataA_o (rdataA),
        .rdataB_o (rdataB)
    );

    hazardUnit uHazard (
        .idRs_i         (idRs),
        .idRt_i         (idRt),
        .exCtl_i        (idEx),
        .memCtl_i       (exMem),
        .wbCtl_i        (memWb),
        .fwdA_o         (fwdA),
        .fwdB_o         (fwdB),
        .loadUseStall_o (loadUseStall)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            idEx <= '0;
        end else if (!freeze) begin
            // Bubble on flush or load-use
            if (branchTaken || loadUseStall) begin
                idEx <= '0;
            end else begin
                idEx.ctrl   <= idCtrl;
                idEx.pc     <= ifId.pcPlus4;
                idEx.rs     <= idRs;
                idEx.rt     <= idRt;
                idEx.dest   <= idDest;
                idEx.rsData <= rdataA;
                idEx.rtData <= rdataB;
                idEx.imm    <= idImm;
            end
        end
    end

    ////////////////////////////////////////
    // EX stage
    ////////////////////////////////////////

    always_comb begin
        exRsFwd = fwdMux(fwdA, idEx.rsData);
        exRtFwd = fwdMux(fwdB, idEx.rtData);
    end

    assign exIsBranch = idEx.ctrl.beq || idEx.ctrl.bne;

    // Branch adds the shifted offset to PC+4
    assign aluOpA = exIsBranch ? idEx.pc : exRsFwd;

    // Link data for jal rides the B operand
    always_comb begin
        if (idEx.ctrl.link) begin
            aluOpB = idEx.pc;
        end else if (exIsBranch) begin
            aluOpB = {idEx.imm[dataWidth-3:0], 2'b00};
        end else if (idEx.ctrl.aluSrcImm) begin
            aluOpB = idEx.imm;
        end else begin
            aluOpB = exRtFwd;
        end
    end

    alu uAlu (
        .aluOp_i (idEx.ctrl.aluOp),
        .opA_i   (aluOpA),
        .opB_i   (aluOpB),
        .res_o   (aluRes),
        .sum_o   (aluSum)
    );

    // Compare on forwarded operands
    assign branchTaken = (idEx.ctrl.beq && (exRsFwd == exRtFwd)) ||
                         (idEx.ctrl.bne && (exRsFwd != exRtFwd));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exMem <= '0;
        end else if (!freeze) begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.aluRes    <= aluRes;
            exMem.storeData <= exRtFwd;
            exMem.dest      <= idEx.dest;
        end
    end

    ////////////////////////////////////////
    // MEM stage
    ////////////////////////////////////////

    // Strobes stay up through a stall, registers frozen
    assign dcacheRen_o   = exMem.memRead;
    assign dcacheWen_o   = exMem.memWrite;
    assign dcacheAddr_o  = exMem.aluRes[31:2];
    assign dcacheWdata_o = exMem.storeData;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            memWb <= '0;
        end else if (!freeze) begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.aluRes   <= exMem.aluRes;
            // Read data valid once stall drops
            memWb.loadData <= dcacheRdata_i;
            memWb.dest     <= exMem.dest;
        end
    end

    ////////////////////////////////////////
    // WB stage
    ////////////////////////////////////////

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluRes;

endmodule

// File: design/mipsPkg.sv
package mipsPkg;

    // Datapath sizing
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    // Return address register for jal
    localparam int linkReg = 31;

    // Fetch address after reset
    localparam logic [dataWidth-1:0] resetPc = '0;

    // All-zero word decodes as sll r0,r0,0
    localparam logic [31:0] nopInst = '0;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////

    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    // R-type function field
    typedef enum logic [5:0] {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluPass
    } aluOpE;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdMem = 2'd1,
        fwdWb  = 2'd2
    } fwdSelE;

    ////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  beq;
        logic  bne;
        logic  jumpImm;
        logic  jumpReg;
        logic  link;
        logic  regDst;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic [31:0]          inst;
        logic [dataWidth-1:0] pcPlus4;
    } ifIdT;

    // pc carries PC+4 of the instruction, base for branches and jal
    typedef struct packed {
        ctrlT                    ctrl;
        logic [dataWidth-1:0]    pc;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    imm;
    } idExT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic                    memRead;
        logic                    memWrite;
        logic [dataWidth-1:0]    aluRes;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] dest;
    } exMemT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic [dataWidth-1:0]    aluRes;
        logic [dataWidth-1:0]    loadData;
        logic [regAddrWidth-1:0] dest;
    } memWbT;

endpackage

// File: design/regFile.sv
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    we_i,
    input  logic [regAddrWidth-1:0] waddr_i,
    input  logic [dataWidth-1:0]    wdata_i,
    input  logic [regAddrWidth-1:0] raddrA_i,
    input  logic [regAddrWidth-1:0] raddrB_i,
    output logic [dataWidth-1:0]    rdataA_o,
    output logic [dataWidth-1:0]    rdataB_o
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];
    logic                 wrValid;

    // Writes to r0 are dropped
    assign wrValid = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs <= '{default: '0};
        end else if (wrValid) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-before-read bypass, r0 pinned to zero
    assign rdataA_o = (raddrA_i == '0)                      ? '0      :
                      (wrValid && (waddr_i == raddrA_i))    ? wdata_i :
                      regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0)                      ? '0      :
                      (wrValid && (waddr_i == raddrB_i))    ? wdata_i :
                      regs[raddrB_i];

endmodule

// File: mipsPipeline.f
+incdir+verif
design/mipsPkg.sv
design/mipsControl.sv
design/regFile.sv
design/alu.sv
design/hazardUnit.sv
design/mipsPipeline.sv
verif/mipsPipelineTb.sv

// File: run.sh
#!/bin/bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module mipsPipelineTb \
    -f mipsPipeline.f \
    -o VmipsPipelineTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VmipsPipelineTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0

// File: verif/mipsTests.svh
`ifndef MIPS_TESTS_SVH
`define MIPS_TESTS_SVH

////////////////////////////////////////
// Encoders and program loading
////////////////////////////////////////

function automatic logic [31:0] encR(input functE fn, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] encI(input opcodeE op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encJ(input opcodeE op, input logic [25:0] idx);
    return {op, idx};
endfunction

// Depends on all eight address bits
function automatic logic [31:0] fillWord(input logic [7:0] a);
    return {a ^ 8'hC3, ~a, a, a ^ 8'h3C};
endfunction

// Reset goes up, memories refilled
task automatic beginProgram();
    @(posedge clk);
    reset_i <= 1'b1;
    for (int i = 0; i < memWords; i++) begin
        imem[i]    = nopInst;
        dmem[i]    <= fillWord(8'(i));
        written[i] <= 1'b0;
    end
    markerSeen <= 1'b0;
    progLen    = 0;
endtask

task automatic putInst(input logic [31:0] w);
    imem[progLen] = w;
    progLen++;
endtask

// Marker store, then spin on itself
task automatic runProgram();
    putInst(encI(opSw, 5'd0, 5'd0, 16'(markerWord * 4)));
    putInst(encJ(opJ, 26'(progLen)));
    budget = budget + 20 * progLen + 20;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    wait (markerSeen);
    @(posedge clk);
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic aluForwardTest();
    logic [31:0] r [10];
    beginProgram();
    putInst(encI(opAddi, 5'd0, 5'd1, 16'd7));
    putInst(encI(opAddi, 5'd0, 5'd2, 16'hFFFD));
    putInst(encR(fnAdd, 5'd1, 5'd2, 5'd3));
    putInst(encR(fnSub, 5'd3, 5'd1, 5'd4));
    putInst(encR(fnAnd, 5'd4, 5'd3, 5'd5));
    putInst(encR(fnOr, 5'd5, 5'd2, 5'd6));
    putInst(encR(fnSlt, 5'd2, 5'd1, 5'd7));
    putInst(encR(fnSlt, 5'd1, 5'd2, 5'd8));
    putInst(encI(opAddi, 5'd6, 5'd9, 16'd100));
    for (int i = 3; i <= 9; i++) begin
        putInst(encI(opSw, 5'd0, 5'(i), 16'((i - 3) * 4)));
    end
    runProgram();
    // Sequential evaluation of the same program
    r[1] = 32'd7;
    r[2] = 32'hFFFF_FFFD;
    r[3] = r[1] + r[2];
    r[4] = r[3] - r[1];
    r[5] = r[4] & r[3];
    r[6] = r[5] | r[2];
    r[7] = ($signed(r[2]) < $signed(r[1])) ? 32'd1 : 32'd0;
    r[8] = ($signed(r[1]) < $signed(r[2])) ? 32'd1 : 32'd0;
    r[9] = r[6] + 32'd100;
    for (int i = 3; i <= 9; i++) begin
        checkVal($sformatf("dmem[%0d]", i - 3), r[i], dmem[i - 3]);
    end
endtask

task automatic loadUseTest();
    beginProgram();
    putInst(encI(opLw, 5'd0, 5'd1, 16'd16));
    putInst(encR(fnAdd, 5'd1, 5'd1, 5'd2));
    putInst(encI(opSw, 5'd0, 5'd2, 16'd40));
    putInst(encI(opLw, 5'd0, 5'd3, 16'd20));
    putInst(encR(fnAdd, 5'd3, 5'd1, 5'd4));
    putInst(encI(opSw, 5'd0, 5'd4, 16'd44));
    runProgram();
    checkVal("dmem[10]", fillWord(8'd4) + fillWord(8'd4), dmem[10]);
    checkVal("dmem[11]", fillWord(8'd5) + fillWord(8'd4), dmem[11]);
endtask

task automatic branchTest();
    beginProgram();
    putInst(encI(opAddi, 5'd0, 5'd1, 16'd5));
    putInst(encI(opAddi, 5'd0, 5'd2, 16'd5));
    putInst(encI(opAddi, 5'd0, 5'd3, 16'd9));
    // Taken beq skips two stores
    putInst(encI(opBeq, 5'd1, 5'd2, 16'd2));
    putInst(encI(opSw, 5'd0, 5'd1, 16'd0));
    putInst(encI(opSw, 5'd0, 5'd1, 16'd4));
    putInst(encI(opSw, 5'd0, 5'd1, 16'd8));
    putInst(encI(opBeq, 5'd1, 5'd3, 16'd1));
    putInst(encI(opSw, 5'd0, 5'd3, 16'd12));
    putInst(encI(opBne, 5'd1, 5'd3, 16'd2));
    putInst(encI(opSw, 5'd0, 5'd3, 16'd16));
    putInst(encI(opSw, 5'd0, 5'd3, 16'd20));
    putInst(encI(opSw, 5'd0, 5'd2, 16'd24));
    putInst(encI(opBne, 5'd1, 5'd2, 16'd1));
    putInst(encI(opSw, 5'd0, 5'd2, 16'd28));
    runProgram();
    checkVal("dmem[0]", fillWord(8'd0), dmem[0]);
    checkVal("dmem[1]", fillWord(8'd1), dmem[1]);
    checkVal("dmem[2]", 32'd5, dmem[2]);
    checkVal("dmem[3]", 32'd9, dmem[3]);
    checkVal("dmem[4]", fillWord(8'd4), dmem[4]);
    checkVal("dmem[5]", fillWord(8'd5), dmem[5]);
    checkVal("dmem[6]", 32'd5, dmem[6]);
    checkVal("dmem[7]", 32'd5, dmem[7]);
endtask

task automatic jumpLinkTest();
    int jalIdx;
    jalIdx = 1;
    beginProgram();
    putInst(encI(opAddi, 5'd0, 5'd5, 16'd3));
    putInst(encJ(opJal, 26'd6));
    putInst(encI(opSw, 5'd0, 5'd5, 16'd4));
    putInst(encJ(opJ, 26'd10));
    putInst(encI(opSw, 5'd0, 5'd5, 16'd8));
    putInst(nopInst);
    // Subroutine, spacer keeps r31 out of the jr read window
    putInst(encI(opSw, 5'd0, 5'd31, 16'd0));
    putInst(encI(opAddi, 5'd0, 5'd6, 16'd1));
    putInst(encR(fnJr, 5'd31, 5'd0, 5'd0));
    putInst(encI(opSw, 5'd0, 5'd5, 16'd12));
    runProgram();
    checkVal("dmem[0]", 32'(jalIdx * 4 + 4), dmem[0]);
    checkVal("dmem[1]", 32'd3, dmem[1]);
    checkVal("dmem[2]", fillWord(8'd2), dmem[2]);
    checkVal("dmem[3]", fillWord(8'd3), dmem[3]);
endtask

`endif

// File: verif/mipsPipelineTb.sv
`timescale 1ns/10ps

module mipsPipelineTb import mipsPkg::*; ();

    localparam int memWords   = 256;
    // Word index of the end-of-program store
    localparam int markerWord = 255;

    logic        clk;
    logic        reset_i;
    logic        icacheRen_o;
    logic [29:0] icacheAddr_o;
    logic [31:0] icacheRdata_i;
    logic        icacheStall_i;
    logic        dcacheRen_o;
    logic        dcacheWen_o;
    logic [29:0] dcacheAddr_o;
    logic [31:0] dcacheWdata_o;
    logic [31:0] dcacheRdata_i;
    logic        dcacheStall_i;

    // Memory models
    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    logic        written [memWords];

    logic stallEn;
    logic markerSeen;
    int   progLen;
    int   cycleCount;
    int   budget;
    int   errorCount;

    mipsPipeline dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .icacheRen_o   (icacheRen_o),
        .icacheAddr_o  (icacheAddr_o),
        .icacheRdata_i (icacheRdata_i),
        .icacheStall_i (icacheStall_i),
        .dcacheRen_o   (dcacheRen_o),
        .dcacheWen_o   (dcacheWen_o),
        .dcacheAddr_o  (dcacheAddr_o),
        .dcacheWdata_o (dcacheWdata_o),
        .dcacheRdata_i (dcacheRdata_i),
        .dcacheStall_i (dcacheStall_i)
    );

    // 10 ns period
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Cache port models
    ////////////////////////////////////////

    // Both memories answer in the same cycle
    assign icacheRdata_i = imem[icacheAddr_o[7:0]];
    // Data word only behind the read strobe
    assign dcacheRdata_i = dcacheRen_o ? dmem[dcacheAddr_o[7:0]] : 32'hDEAD_BEEF;

    always @(posedge clk) begin
        // Fetch strobe is low only in reset
        checkVal("icacheRen_o", 32'(!reset_i), 32'(icacheRen_o));
        if (stallEn && !reset_i) begin
            icacheStall_i <= ($urandom % 4) == 0;
            dcacheStall_i <= ($urandom % 4) == 0;
        end else begin
            icacheStall_i <= 1'b0;
            dcacheStall_i <= 1'b0;
        end
        // Store takes effect only on a cycle without freeze
        if (!reset_i && dcacheWen_o && !icacheStall_i && !dcacheStall_i) begin
            if (dcacheAddr_o[7:0] == 8'(markerWord)) begin
                markerSeen <= 1'b1;
            end else if (written[dcacheAddr_o[7:0]]) begin
                $display("Store to word %0d was written twice", dcacheAddr_o[7:0]);
                $display("*** FAILED ***");
                $fatal(1);
            end else begin
                dmem[dcacheAddr_o[7:0]]    <= dcacheWdata_o;
                written[dcacheAddr_o[7:0]] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks and watchdog
    ////////////////////////////////////////

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("Error %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // Budget grows by 20 cycles per program word
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > budget) begin
            $display("Timeout after %0d cycles, program never reached its end", cycleCount);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    `include "mipsTests.svh"

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        reset_i       = 1'b1;
        icacheStall_i = 1'b0;
        dcacheStall_i = 1'b0;
        stallEn       = 1'b0;
        progLen       = 0;
        cycleCount    = 0;
        budget        = 200;
        errorCount    = 0;
        void'($urandom(58617));

        aluForwardTest();
        loadUseTest();
        branchTest();
        jumpLinkTest();

        // Same programs again with random cache stalls
        stallEn = 1'b1;
        aluForwardTest();
        loadUseTest();
        branchTest();
        jumpLinkTest();

        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
